/* design/scc_irq.sv */
module scc_irq (
	input  logic               clk,
	input  logic               reset_hw,
	input  scc_pkg::chan_cfg_t i_cfg,
	input  scc_pkg::cmd_t      i_cmd,
	input  logic               i_rx_avail,
	input  logic               i_tx_idle,
	input  logic               i_dcd,
	output scc_pkg::irq_pend_t o_pend,
	output logic               o_dcd_view,
	output logic               o_irq_n
);
	import scc_pkg::*;

	logic latch_open;  // ext/status latch transparent
	logic dcd_latch;
	logic ex_ip;
	logic tx_ip;
	logic rx_first;    // first char armed
	logic tx_idle_q;
	logic do_latch;
	logic tx_done;
	logic rx_mode_hit;

	// the latch follows the pin while open, so a mismatch is a fresh edge
	assign do_latch = latch_open & i_cfg.dcd_ie & (i_dcd != dcd_latch);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			ex_ip      <= 1'b0;
		end else begin
			if (i_cmd.soft_reset || latch_open)
				dcd_latch <= i_dcd; // captures on the closing edge too
			if (i_cmd.soft_reset || i_cmd.reset_ext) begin
				latch_open <= 1'b1;
				ex_ip      <= 1'b0;
			end else if (do_latch) begin
				latch_open <= 1'b0; // hold until software acks
				if (i_cfg.ext_int_en)
					ex_ip <= 1'b1;
			end
		end
	end

	assign o_dcd_view = i_cfg.dcd_ie ? dcd_latch : i_dcd;

	// tx interrupt on the shifter going quiet
	assign tx_done = i_tx_idle & ~tx_idle_q;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			tx_idle_q <= 1'b1;
			tx_ip     <= 1'b0;
		end else begin
			tx_idle_q <= i_tx_idle | i_cmd.soft_reset; // shifter forced idle by a reset
			if (i_cmd.soft_reset || i_cmd.reset_tx_ip)
				tx_ip <= 1'b0;
			else if (tx_done && i_cfg.tx_int_en)
				tx_ip <= 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			rx_first <= 1'b1;
		else if (i_cmd.soft_reset || i_cmd.rx_first_en)
			rx_first <= 1'b1;
		else if (i_cmd.data_read)
			rx_first <= 1'b0; // first char consumed
	end

	// mode 10 every char, mode 01 first char only, 00 and 11 never
	assign rx_mode_hit = (i_cfg.rx_int_mode == 2'b10) |
		((i_cfg.rx_int_mode == 2'b01) & rx_first);

	assign o_pend = '{
		rx: i_cfg.rx_en & i_rx_avail & rx_mode_hit,
		tx: tx_ip,
		ex: ex_ip
	};

	assign o_irq_n = ~(i_cfg.mie & (o_pend.rx | o_pend.tx | o_pend.ex));

endmodule

/* design/scc_pkg.sv */
package scc_pkg;

	// plain vector types
	typedef logic [7:0] byte_t;     // data or register byte
	typedef logic [3:0] reg_idx_t;  // register pointer, WR0 bits 2:0 plus point high
	typedef logic [2:0] wr0_cmd_t;  // WR0 bits 5:3
	typedef logic [1:0] rst_code_t; // WR9 bits 7:6
	typedef logic [2:0] bit_cnt_t;  // data bit position in a character

	// serial bit timing, fixed divisor
	localparam int BAUD_DIV = 16;   // clk cycles per bit
	localparam int BAUD_W = $clog2(BAUD_DIV);

	typedef logic [BAUD_W-1:0] baud_cnt_t;

	localparam baud_cnt_t BAUD_END = baud_cnt_t'(BAUD_DIV - 1);     // last cycle of a bit
	localparam baud_cnt_t BAUD_MID = baud_cnt_t'(BAUD_DIV / 2 - 1); // start bit centre

	// register indices
	localparam reg_idx_t RR_0    = 4'd0;  // also WR0, the command/pointer register
	localparam reg_idx_t RR_1    = 4'd1;
	localparam reg_idx_t RR_3    = 4'd3;
	localparam reg_idx_t RR_DATA = 4'd8;  // receive buffer through the pointer
	localparam reg_idx_t RR_15   = 4'd15;
	localparam reg_idx_t WR_1    = 4'd1;
	localparam reg_idx_t WR_3    = 4'd3;
	localparam reg_idx_t WR_9    = 4'd9;
	localparam reg_idx_t WR_15   = 4'd15;

	// WR0 command field
	localparam wr0_cmd_t CMD_POINT_HIGH  = 3'b001; // pointer gets bit 3 set
	localparam wr0_cmd_t CMD_RESET_EXT   = 3'b010; // reopen ext/status latch
	localparam wr0_cmd_t CMD_RX_FIRST    = 3'b100; // arm first char interrupt
	localparam wr0_cmd_t CMD_RESET_TX_IP = 3'b101;

	// WR9 reset field
	localparam rst_code_t RST_CHAN = 2'b10; // channel A reset
	localparam rst_code_t RST_HW   = 2'b11; // force hardware reset

	localparam byte_t WR15_RESET = 8'hf8; // ext/status enables after hw reset
	localparam byte_t RR1_CONST  = 8'h07; // all sent, residue code 011

	// cpu bus as seen by the register block
	typedef struct packed {
		logic  cs;
		logic  we;
		logic  data_sel;  // 1 data, 0 control
		logic  chan_a;    // 1 channel A, 0 channel B
		byte_t wdata;
	} bus_req_t;

	// channel configuration bits feeding the interrupt logic
	typedef struct packed {
		logic [1:0] rx_int_mode; // WR1 4:3
		logic       tx_int_en;   // WR1 1
		logic       ext_int_en;  // WR1 0
		logic       rx_en;       // WR3 0
		logic       dcd_ie;      // WR15 3
		logic       mie;         // WR9 3
	} chan_cfg_t;

	// single cycle command strobes
	typedef struct packed {
		logic soft_reset;
		logic hw_soft_reset;
		logic reset_ext;
		logic reset_tx_ip;
		logic rx_first_en;
		logic data_read;
	} cmd_t;

	typedef struct packed {
		logic rx;
		logic tx;
		logic ex;
	} irq_pend_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

/* design/scc_regs.sv */
module scc_regs (
	input  logic               clk,
	input  logic               reset_hw,
	input  scc_pkg::bus_req_t  i_bus,
	input  logic               i_rx_valid,
	input  scc_pkg::byte_t     i_rx_data,
	input  logic               i_tx_ready,
	input  logic               i_tx_idle,
	input  logic               i_dcd_view,
	input  scc_pkg::irq_pend_t i_pend,
	output scc_pkg::byte_t     o_rdata,
	output scc_pkg::chan_cfg_t o_cfg,
	output scc_pkg::cmd_t      o_cmd,
	output logic               o_tx_valid,
	output scc_pkg::byte_t     o_tx_data,
	output logic               o_rx_avail,
	output logic               o_chan_reset
);
	import scc_pkg::*;

	reg_idx_t rindex;      // pointer in use for the current access
	reg_idx_t rindex_next; // written pointer, taken over once cs drops
	byte_t    wr1;
	byte_t    wr3;
	logic     wr9_mie;
	byte_t    wr15;
	byte_t    tx_hold;     // transmit holding register
	logic     tx_full;
	byte_t    rx_data;     // receive data register
	logic     rx_avail;

	logic      ctl_acc;
	logic      ctl_wr;
	logic      data_wr;
	logic      data_rd;
	logic      wr0_wr;
	wr0_cmd_t  wr0_cmd;
	rst_code_t wr9_code;
	logic      soft_reset;
	logic      hw_soft_reset;

	// channel B accesses fall through every decode below
	assign ctl_acc = i_bus.cs & i_bus.chan_a & ~i_bus.data_sel;
	assign ctl_wr  = ctl_acc & i_bus.we;
	assign data_wr = i_bus.cs & i_bus.chan_a & i_bus.data_sel & i_bus.we;
	assign data_rd = i_bus.cs & i_bus.chan_a & i_bus.data_sel & ~i_bus.we;
	assign wr0_wr  = ctl_wr & (rindex == RR_0);

	assign wr0_cmd  = i_bus.wdata[5:3];
	assign wr9_code = i_bus.wdata[7:6];

	assign soft_reset    = ctl_wr & (rindex == WR_9) &
		((wr9_code == RST_CHAN) | (wr9_code == RST_HW));
	assign hw_soft_reset = ctl_wr & (rindex == WR_9) & (wr9_code == RST_HW);

	assign o_cmd = '{
		soft_reset:    soft_reset,
		hw_soft_reset: hw_soft_reset,
		reset_ext:     wr0_wr & (wr0_cmd == CMD_RESET_EXT),
		reset_tx_ip:   wr0_wr & (wr0_cmd == CMD_RESET_TX_IP),
		rx_first_en:   wr0_wr & (wr0_cmd == CMD_RX_FIRST),
		data_read:     data_rd
	};
	assign o_chan_reset = soft_reset; // to the serializers

	// pointer moves only between accesses so read data stays put while cs is high
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex      <= '0;
			rindex_next <= '0;
		end else begin
			if (!i_bus.cs)
				rindex <= rindex_next;
			if (wr0_wr)
				rindex_next <= {wr0_cmd == CMD_POINT_HIGH, i_bus.wdata[2:0]};
			else if (ctl_acc)
				rindex_next <= '0; // back to WR0/RR0 after any other access
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			wr1     <= '0;
			wr3     <= '0;
			wr9_mie <= 1'b0;
			wr15    <= WR15_RESET;
		end else begin
			if (soft_reset)
				wr1 <= {2'b00, wr1[5], 2'b00, wr1[2], 2'b00}; // 5 and 2 survive
			else if (ctl_wr && rindex == WR_1)
				wr1 <= i_bus.wdata;
			if (ctl_wr && rindex == WR_3)
				wr3 <= i_bus.wdata;
			if (ctl_wr && rindex == WR_9)
				wr9_mie <= i_bus.wdata[3];
			if (hw_soft_reset)
				wr15 <= WR15_RESET;
			else if (ctl_wr && rindex == WR_15)
				wr15 <= i_bus.wdata;
		end
	end

	// holding register, a new write just overwrites a pending byte
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			tx_full <= 1'b0;
		else if (soft_reset)
			tx_full <= 1'b0;
		else if (data_wr)
			tx_full <= 1'b1;
		else if (tx_full && i_tx_ready)
			tx_full <= 1'b0; // handed to the shifter
	end

	always_ff @(posedge clk) begin
		if (data_wr)
			tx_hold <= i_bus.wdata;
		if (i_rx_valid)
			rx_data <= i_rx_data; // overrun just replaces
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			rx_avail <= 1'b0;
		else if (soft_reset)
			rx_avail <= 1'b0;
		else if (i_rx_valid)
			rx_avail <= 1'b1;
		else if (data_rd)
			rx_avail <= 1'b0;
	end

	assign o_cfg = '{
		rx_int_mode: wr1[4:3],
		tx_int_en:   wr1[1],
		ext_int_en:  wr1[0],
		rx_en:       wr3[0],
		dcd_ie:      wr15[3],
		mie:         wr9_mie
	};

	assign o_tx_valid = tx_full;
	assign o_tx_data  = tx_hold;
	assign o_rx_avail = rx_avail;

	// read mux
	always_comb begin
		o_rdata = 8'hff; // channel B and unbuilt registers
		if (i_bus.chan_a) begin
			if (i_bus.data_sel)
				o_rdata = rx_data;
			else begin
				case (rindex)
					RR_0:    o_rdata = {1'b0, 1'b1, 2'b00, i_dcd_view,
						~tx_full & i_tx_idle, 1'b0, rx_avail};
					RR_1:    o_rdata = RR1_CONST;
					RR_3:    o_rdata = {2'b00, i_pend.rx, i_pend.tx, i_pend.ex, 3'b000};
					RR_DATA: o_rdata = rx_data;
					RR_15:   o_rdata = {wr15[7:3], 1'b0, wr15[1], 1'b0};
					default: o_rdata = 8'hff;
				endcase
			end
		end
	end

endmodule

/* design/scc_rx.sv */
module scc_rx (
	input  logic           clk,
	input  logic           reset_hw,
	input  logic           i_soft_reset,
	input  logic           i_rxd,
	output logic           o_valid,
	output scc_pkg::byte_t o_data
);
	import scc_pkg::*;

	logic      rxd_meta;
	logic      rxd_sync;
	logic      rxd_prev;
	rx_state_e state;
	baud_cnt_t baud_cnt;
	bit_cnt_t  bit_cnt;
	byte_t     shreg;     // fills from the top, lsb first on the line
	logic      valid;
	logic      start_edge;
	logic      bit_end;

	// two flop synchronizer plus one stage for edge detect
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= i_rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign start_edge = rxd_prev & ~rxd_sync; // mark to space
	assign bit_end    = (baud_cnt == BAUD_END);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			valid    <= 1'b0;
		end else if (i_soft_reset) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			valid    <= 1'b0;
		end else begin
			valid    <= 1'b0;
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (start_edge)
						state <= RX_START;
				end
				RX_START: if (baud_cnt == BAUD_MID) begin
					baud_cnt <= '0; // from here on every count lands mid-bit
					bit_cnt  <= '0;
					state    <= rxd_sync ? RX_IDLE : RX_DATA; // glitch, not a start
				end
				RX_DATA: if (bit_end) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (bit_end) begin
					state <= RX_IDLE;
					valid <= rxd_sync; // low stop bit, byte dropped
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shreg <= {rxd_sync, shreg[7:1]};
	end

	assign o_valid = valid;
	assign o_data  = shreg; // stable until the next char's data bits

endmodule

/* design/scc_top.sv */
module scc_top (
	input  logic           clk,
	input  logic           reset_hw,
	input  logic           i_cs,
	input  logic           i_we,
	input  logic [1:0]     i_rs,     // [1] data/ctl, [0] A/B
	input  scc_pkg::byte_t i_wdata,
	input  logic           i_rxd,
	input  logic           i_dcd,
	output scc_pkg::byte_t o_rdata,
	output logic           o_irq_n,
	output logic           o_txd,
	output logic           o_rts
);
	import scc_pkg::*;

	bus_req_t  bus;
	chan_cfg_t cfg;
	cmd_t      cmd;
	irq_pend_t pend;
	logic      tx_valid;
	logic      tx_ready;
	logic      tx_idle;
	byte_t     tx_data;
	logic      rx_valid;
	byte_t     rx_data;
	logic      rx_avail;
	logic      dcd_view;
	logic      chan_reset;

	assign bus = '{
		cs:       i_cs,
		we:       i_we,
		data_sel: i_rs[1],
		chan_a:   i_rs[0],
		wdata:    i_wdata
	};

	scc_regs u_regs (
		.clk          (clk),
		.reset_hw     (reset_hw),
		.i_bus        (bus),
		.i_rx_valid   (rx_valid),
		.i_rx_data    (rx_data),
		.i_tx_ready   (tx_ready),
		.i_tx_idle    (tx_idle),
		.i_dcd_view   (dcd_view),
		.i_pend       (pend),
		.o_rdata      (o_rdata),
		.o_cfg        (cfg),
		.o_cmd        (cmd),
		.o_tx_valid   (tx_valid),
		.o_tx_data    (tx_data),
		.o_rx_avail   (rx_avail),
		.o_chan_reset (chan_reset)
	);

	scc_irq u_irq (
		.clk        (clk),
		.reset_hw   (reset_hw),
		.i_cfg      (cfg),
		.i_cmd      (cmd),
		.i_rx_avail (rx_avail),
		.i_tx_idle  (tx_idle),
		.i_dcd      (i_dcd),
		.o_pend     (pend),
		.o_dcd_view (dcd_view),
		.o_irq_n    (o_irq_n)
	);

	scc_tx u_tx (
		.clk          (clk),
		.reset_hw     (reset_hw),
		.i_soft_reset (chan_reset),
		.i_valid      (tx_valid),
		.i_data       (tx_data),
		.o_ready      (tx_ready),
		.o_idle       (tx_idle),
		.o_txd        (o_txd)
	);

	scc_rx u_rx (
		.clk          (clk),
		.reset_hw     (reset_hw),
		.i_soft_reset (chan_reset),
		.i_rxd        (i_rxd),
		.o_valid      (rx_valid),
		.o_data       (rx_data)
	);

	assign o_rts = rx_avail; // raised while a char waits

endmodule

/* design/scc_tx.sv */
module scc_tx (
	input  logic           clk,
	input  logic           reset_hw,
	input  logic           i_soft_reset,
	input  logic           i_valid,
	input  scc_pkg::byte_t i_data,
	output logic           o_ready,
	output logic           o_idle,
	output logic           o_txd
);
	import scc_pkg::*;

	tx_state_e state;
	baud_cnt_t baud_cnt;
	bit_cnt_t  bit_cnt;
	byte_t     shreg;     // lsb goes out next
	logic      txd;
	logic      bit_end;

	assign bit_end = (baud_cnt == BAUD_END);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1; // mark
		end else if (i_soft_reset) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			txd      <= 1'b1;
		end else begin
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					if (i_valid) begin
						state <= TX_START;
						txd   <= 1'b0; // start bit
					end
				end
				TX_START: if (bit_end) begin
					state   <= TX_DATA;
					txd     <= shreg[0];
					bit_cnt <= '0;
				end
				TX_DATA: if (bit_end) begin
					if (bit_cnt == 3'd7) begin
						state <= TX_STOP;
						txd   <= 1'b1;
					end else begin
						txd     <= shreg[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_STOP: if (bit_end)
					state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_valid)
			shreg <= i_data;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			shreg <= {1'b0, shreg[7:1]};
	end

	assign o_ready = (state == TX_IDLE); // takes a byte only between chars
	assign o_idle  = (state == TX_IDLE);
	assign o_txd   = txd;

endmodule

/* files.f */
design/scc_pkg.sv
design/scc_regs.sv
design/scc_irq.sv
design/scc_tx.sv
design/scc_rx.sv
design/scc_top.sv
testbench/tb_scc.sv

/* testbench/scc_tests.txt */
# columns: op target value wait, all hex; ops W R S T D Q(o_irq_n) O(o_rts)
# target: 00-0f channel A register, 10 A data, 20 B control, 30 B data
R 00 44 0
R 0f f8 0
R 01 07 0
Q 00 01 0
W 0f 2f 0
R 0f 2a 0
W 0f f8 0
W 20 0f 0
R 00 44 0
R 20 ff 0
R 30 ff 0
# transmit
W 10 a5 0
T 00 a5 0
R 00 44 1
W 10 3c 0
W 10 c3 0
R 00 40 0
T 00 3c 0
T 00 c3 0
R 00 44 1
# receive
S 00 5a 0
R 00 45 0
O 00 01 0
R 10 5a 0
R 00 44 0
O 00 00 0
# rx interrupts, mode 10 then mode 01
W 03 01 0
W 01 10 0
W 09 08 0
Q 00 01 0
S 00 81 0
Q 00 00 1
R 03 20 0
R 10 81 0
Q 00 01 0
S 00 7e 0
Q 00 00 1
R 10 7e 0
W 01 08 0
S 00 11 0
Q 00 01 0
R 10 11 0
W 00 20 0
S 00 22 0
Q 00 00 1
R 10 22 0
Q 00 01 0
S 00 33 0
Q 00 01 0
R 10 33 0
# dcd latch, then tx interrupt
W 01 01 0
D 00 01 0
Q 00 00 1
R 03 08 0
R 00 4c 0
D 00 00 0
R 00 4c 0
W 00 10 0
Q 00 00 1
R 00 44 0
W 00 10 0
Q 00 01 0
R 03 00 0
W 01 02 0
W 10 96 0
T 00 96 0
Q 00 00 1
R 03 10 0
W 00 28 0
Q 00 01 0
# channel reset, then force hardware reset
W 01 37 0
S 00 44 0
Q 00 00 1
W 09 88 0
Q 00 01 0
R 00 44 0
O 00 00 0
S 00 55 0
Q 00 01 0
R 10 55 0
W 0f 00 0
R 0f 00 0
W 09 c8 0
R 0f f8 0

/* testbench/tb_scc.sv */
module tb_scc;
	import scc_pkg::*;

	localparam logic [31:0] SEED = 32'h931a_91e6;
	localparam int IRQ_WAIT = 12 * BAUD_DIV;   // cycles allowed for a late interrupt
	localparam int TX_WAIT  = 24 * BAUD_DIV;   // cycles allowed for a byte on o_txd
	localparam int POLL_MAX = 12 * BAUD_DIV;   // register reads per poll

	// one line of the test file
	typedef struct packed {
		byte_t op;    // ascii letter
		byte_t tgt;   // target code as listed in the data file
		byte_t val;   // write data or expected value
		logic  poll;  // wait for the value instead of checking once
	} test_op_t;

	logic       clk;
	logic       reset_hw;
	logic       cs;
	logic       we;
	logic [1:0] rs;
	byte_t      wdata;
	logic       rxd;
	logic       dcd;
	byte_t      rdata;
	logic       irq_n;
	logic       txd;
	logic       rts;

	test_op_t ops[$];
	byte_t    tx_q[$];        // bytes seen on o_txd in arrival order
	logic     tests_loaded;

	scc_top dut0 (
		.clk      (clk),
		.reset_hw (reset_hw),
		.i_cs     (cs),
		.i_we     (we),
		.i_rs     (rs),
		.i_wdata  (wdata),
		.i_rxd    (rxd),
		.i_dcd    (dcd),
		.o_rdata  (rdata),
		.o_irq_n  (irq_n),
		.o_txd    (txd),
		.o_rts    (rts)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %02h actual %02h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// rs is {data, chan_a}
	function automatic logic [1:0] target_rs(input byte_t tgt);
		case (tgt[5:4])
			2'd0: target_rs = 2'b01;    // A control
			2'd1: target_rs = 2'b11;    // A data
			2'd2: target_rs = 2'b00;    // B control
			default: target_rs = 2'b10; // B data
		endcase
	endfunction

	// one cs high cycle followed by two with cs low
	task automatic bus_cycle(input logic wr, input logic [1:0] sel, input byte_t wd,
		output byte_t rd);
		@(posedge clk);
		cs    <= 1'b1;
		we    <= wr;
		rs    <= sel;
		wdata <= wd;
		@(negedge clk);
		rd = rdata;  // mux is settled mid cycle
		@(posedge clk);
		cs <= 1'b0;
		we <= 1'b0;
		@(posedge clk);
	endtask

	// WR0 pointer write where bit 3 doubles as the point high command
	task automatic point_at(input byte_t tgt);
		byte_t unused;
		if (tgt[5:4] == 2'd0 && tgt[3:0] != 4'd0)
			bus_cycle(1'b1, 2'b01, {4'h0, tgt[3:0]}, unused);
	endtask

	task automatic write_reg(input byte_t tgt, input byte_t val);
		byte_t unused;
		point_at(tgt);
		bus_cycle(1'b1, target_rs(tgt), val, unused);
	endtask

	task automatic read_reg(input byte_t tgt, input byte_t exp, input logic poll);
		byte_t got;
		int    tries;
		point_at(tgt);
		bus_cycle(1'b0, target_rs(tgt), 8'h00, got);
		tries = 1;
		while (poll && got !== exp && tries < POLL_MAX) begin // software status poll
			point_at(tgt);
			bus_cycle(1'b0, target_rs(tgt), 8'h00, got);
			tries++;
		end
		compare_byte($sformatf("o_rdata target %02h", tgt), exp, got);
	endtask

	// 8N1 onto i_rxd after a random idle gap
	task automatic send_serial(input byte_t b);
		logic [9:0]  frame;
		int unsigned gap;
		int          i;
		frame = {1'b1, b, 1'b0};
		gap = $urandom % 4;
		repeat (gap * BAUD_DIV) @(posedge clk);
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (BAUD_DIV - 1) @(posedge clk);
		end
	endtask

	task automatic expect_tx(input byte_t exp);
		int waited;
		waited = 0;
		while (tx_q.size() == 0 && waited < TX_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (tx_q.size() == 0) begin
			$display("no byte showed up on o_txd within %0d cycles, wanted %02h", TX_WAIT, exp);
			abort_run();
		end else
			compare_byte("o_txd byte", exp, tx_q.pop_front());
	endtask

	task automatic check_irq(input logic exp, input logic poll);
		int waited;
		waited = 0;
		@(negedge clk);
		while (poll && irq_n !== exp && waited < IRQ_WAIT) begin
			@(negedge clk);
			waited++;
		end
		compare_bit("o_irq_n", exp, irq_n);
	endtask

	task automatic check_rts(input logic exp);
		@(negedge clk);
		compare_bit("o_rts", exp, rts);
	endtask

	task automatic set_dcd(input logic level);
		@(posedge clk);
		dcd <= level;
	endtask

	task automatic run_op(input test_op_t t);
		case (t.op)
			"W": write_reg(t.tgt, t.val);
			"R": read_reg(t.tgt, t.val, t.poll);
			"S": send_serial(t.val);
			"T": expect_tx(t.val);
			"D": set_dcd(t.val[0]);
			"Q": check_irq(t.val[0], t.poll);
			"O": check_rts(t.val[0]);
			default: begin
				$display("test file holds an unknown operation '%c'", t.op);
				abort_run();
			end
		endcase
	endtask

	// whole file into ops before reset ends
	task automatic load_tests();
		int                fd;
		int                n;
		byte_t             ch;
		logic [31:0]       tgt;
		logic [31:0]       val;
		logic [31:0]       flg;
		logic [8*160-1:0]  rest;
		test_op_t          t;
		logic              done;
		fd = $fopen("testbench/scc_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/scc_tests.txt");
			abort_run();
		end
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, " %c", ch);
			if (n != 1)
				done = 1'b1;
			else if (ch == "#")
				n = $fgets(rest, fd); // comment line
			else begin
				n = $fscanf(fd, "%h %h %h", tgt, val, flg);
				if (n != 3) begin
					$display("malformed line in the test file after op '%c'", ch);
					abort_run();
				end
				t.op   = ch;
				t.tgt  = tgt[7:0];
				t.val  = val[7:0];
				t.poll = flg[0];
				ops.push_back(t);
			end
		end
		$fclose(fd);
		if (ops.size() == 0) begin
			$display("test file holds no operations");
			abort_run();
		end
	endtask

	// samples o_txd at mid bit and queues each framed byte
	initial begin
		byte_t b;
		int    i;
		wait (reset_hw === 1'b0);
		forever begin
			@(negedge clk);
			while (txd !== 1'b0)
				@(negedge clk);
			repeat (BAUD_DIV / 2) @(negedge clk);
			compare_bit("o_txd start bit", 1'b0, txd);
			for (i = 0; i < 8; i++) begin
				repeat (BAUD_DIV) @(negedge clk);
				b[i] = txd; // lsb first
			end
			repeat (BAUD_DIV) @(negedge clk);
			compare_bit("o_txd stop bit", 1'b1, txd);
			tx_q.push_back(b);
		end
	end

	// limit scales with the number of test lines
	initial begin
		wait (tests_loaded === 1'b1);
		#(ops.size() * 24 * BAUD_DIV * 20);
		$display("timeout: the test sequence did not finish in time");
		abort_run();
	end

	initial begin
		int k;
		reset_hw     = 1'b1;
		cs           = 1'b0;
		we           = 1'b0;
		rs           = 2'b00;
		wdata        = 8'h00;
		rxd          = 1'b1; // line idles at mark
		dcd          = 1'b0;
		tests_loaded = 1'b0;
		void'($urandom(SEED));
		load_tests();
		tests_loaded = 1'b1;
		repeat (2) @(posedge clk);
		reset_hw <= 1'b0;
		for (k = 0; k < ops.size(); k++)
			run_op(ops[k]);
		repeat (12 * BAUD_DIV) @(posedge clk); // let a stray char land in the queue
		if (tx_q.size() != 0) begin
			$display("o_txd sent %0d byte(s) that no test line expected", tx_q.size());
			abort_run();
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule
